// ==== verilog/rob_config.svh ====
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// usable entries; nick 0 is reserved for "no tag"
`define ROB_DEPTH 15
`define NICK_W 4

`define XLEN 32
`define REG_W 5
`define OP_W 6

`endif

// ==== verilog/robPkg.sv ====
`include "rob_config.svh"

package robPkg;

    typedef logic [`NICK_W-1:0] robNick;

    // codes the backend has to tell apart, any other code is plain ALU work
    typedef enum logic [`OP_W-1:0] {
        OpAlu = 6'd0,
        OpLoadB,
        OpLoadH,
        OpLoadW,
        OpLoadBU,
        OpLoadHU,
        OpStoreB,
        OpStoreH,
        OpStoreW,
        OpBranch,
        OpJal,
        OpJalr
    } opKind;

    typedef struct packed {
        logic [`OP_W-1:0] op;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        robNick           rdNick;
        robNick           rs1Nick;
        logic [`XLEN-1:0] rs1Data;
        robNick           rs2Nick;
        logic [`XLEN-1:0] rs2Data;
    } issuePkt;

    typedef struct packed {
        logic [`REG_W-1:0] regName;
        logic [`XLEN-1:0]  data;
        robNick            nick;
    } commitRec;

    function automatic logic isLoad(logic [`OP_W-1:0] op);
        return op inside {OpLoadB, OpLoadH, OpLoadW, OpLoadBU, OpLoadHU};
    endfunction

    function automatic logic isStore(logic [`OP_W-1:0] op);
        return op inside {OpStoreB, OpStoreH, OpStoreW};
    endfunction

endpackage

// ==== verilog/robIf.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

interface issueIf;
    import robPkg::*;

    logic    en;
    issuePkt pkt;

    modport src (
        output en,
        output pkt
    );

    modport dst (
        input en,
        input pkt
    );
endinterface

interface wbIf;
    import robPkg::*;

    logic             en;
    robNick           nick;
    logic [`XLEN-1:0] data;
    // resolved taken branch, redirect to target
    logic             isBranch;
    logic [`XLEN-1:0] target;

    modport src (
        output en,
        output nick,
        output data,
        output isBranch,
        output target
    );

    modport dst (
        input en,
        input nick,
        input data,
        input isBranch,
        input target
    );
endinterface

// ==== verilog/renameTable.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module renameTable (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              instEn,
    input  logic [`REG_W-1:0] instRd,
    input  logic [`REG_W-1:0] instRs1,
    input  logic [`REG_W-1:0] instRs2,
    input  robPkg::robNick    allocNick,
    input  logic              commitEn,
    input  robPkg::commitRec  commit,
    input  logic              flush,
    output robPkg::robNick    lookupNick1,
    output robPkg::robNick    lookupNick2,
    input  logic              lookupDone1,
    input  logic              lookupDone2,
    input  logic [`XLEN-1:0]  lookupData1,
    input  logic [`XLEN-1:0]  lookupData2,
    output robPkg::robNick    rs1Nick,
    output logic [`XLEN-1:0]  rs1Data,
    output robPkg::robNick    rs2Nick,
    output logic [`XLEN-1:0]  rs2Data
);
    import robPkg::*;

    logic [`XLEN-1:0] regs [32];
    robNick           tags [32];

    // no tag, or the producer is already done, means the value is ready
    function automatic logic [`NICK_W+`XLEN-1:0] resolve(
        robNick           tag,
        logic             done,
        logic [`XLEN-1:0] robData,
        logic [`XLEN-1:0] archData
    );
        if (tag == '0) begin
            return {robNick'(0), archData};
        end
        if (done) begin
            return {robNick'(0), robData};
        end
        return {tag, archData};
    endfunction

    assign lookupNick1 = tags[instRs1];
    assign lookupNick2 = tags[instRs2];

    assign {rs1Nick, rs1Data} = resolve(lookupNick1, lookupDone1, lookupData1, regs[instRs1]);
    assign {rs2Nick, rs2Data} = resolve(lookupNick2, lookupDone2, lookupData2, regs[instRs2]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else if (rdy) begin
            if (commitEn && commit.regName != '0) begin
                regs[commit.regName] <= commit.data;
                // a younger writer keeps its tag
                if (tags[commit.regName] == commit.nick) begin
                    tags[commit.regName] <= '0;
                end
            end
            if (instEn && instRd != '0) begin
                tags[instRd] <= allocNick;
            end
            if (flush) begin
                for (int i = 0; i < 32; i++) begin
                    tags[i] <= '0;
                end
            end
        end
    end

endmodule

// ==== verilog/dispatchRouter.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module dispatchRouter (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             instEn,
    input  logic [`OP_W-1:0] instOp,
    input  logic [`XLEN-1:0] instPc,
    input  logic [`XLEN-1:0] instImm,
    input  robPkg::robNick   allocNick,
    input  robPkg::robNick   rs1Nick,
    input  logic [`XLEN-1:0] rs1Data,
    input  robPkg::robNick   rs2Nick,
    input  logic [`XLEN-1:0] rs2Data,
    issueIf.src              rsIssue,
    issueIf.src              slbIssue,
    input  logic             flush
);
    import robPkg::*;

    logic    toSlb;
    logic    rsEnQ;
    logic    slbEnQ;
    issuePkt pktQ;

    // memory ops go to the store/load buffer
    assign toSlb = isLoad(instOp) || isStore(instOp);

    always_ff @(posedge clk) begin
        if (rst) begin
            rsEnQ  <= 1'b0;
            slbEnQ <= 1'b0;
        end else if (rdy) begin
            rsEnQ  <= instEn && !toSlb && !flush;
            slbEnQ <= instEn && toSlb && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && instEn) begin
            pktQ <= '{
                op:      instOp,
                pc:      instPc,
                imm:     instImm,
                rdNick:  allocNick,
                rs1Nick: rs1Nick,
                rs1Data: rs1Data,
                rs2Nick: rs2Nick,
                rs2Data: rs2Data
            };
        end
    end

    // strobes stay low during a stall
    assign rsIssue.en   = rsEnQ && rdy;
    assign rsIssue.pkt  = pktQ;
    assign slbIssue.en  = slbEnQ && rdy;
    assign slbIssue.pkt = pktQ;

    oneTarget: assert property (@(posedge clk) disable iff (rst)
        !(rsIssue.en && slbIssue.en));

endmodule

// ==== verilog/reorderBuffer.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module reorderBuffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              instEn,
    input  logic [`OP_W-1:0]  instOp,
    input  logic [`REG_W-1:0] instRd,
    input  logic [`XLEN-1:0]  instPc,
    output robPkg::robNick    allocNick,
    output logic              full,
    wbIf.dst                  exWb,
    wbIf.dst                  slbWb,
    input  robPkg::robNick    lookupNick1,
    input  robPkg::robNick    lookupNick2,
    output logic              lookupDone1,
    output logic              lookupDone2,
    output logic [`XLEN-1:0]  lookupData1,
    output logic [`XLEN-1:0]  lookupData2,
    output logic              commitEn,
    output robPkg::commitRec  commit,
    output logic              storeCommitEn,
    output robPkg::robNick    storeCommitNick,
    output logic              flush,
    output logic [`XLEN-1:0]  redirectPc
);
    import robPkg::*;

    logic              busy     [1:`ROB_DEPTH];
    logic              done     [1:`ROB_DEPTH];
    logic              isStoreE [1:`ROB_DEPTH];
    logic              isBranch [1:`ROB_DEPTH];
    logic              taken    [1:`ROB_DEPTH];
    logic [`REG_W-1:0] regName  [1:`ROB_DEPTH];
    logic [`XLEN-1:0]  data     [1:`ROB_DEPTH];
    logic [`XLEN-1:0]  target   [1:`ROB_DEPTH];

    robNick            head;
    robNick            tail;
    logic [`NICK_W-1:0] count;
    logic              allocGo;
    logic              headGo;
    logic              commitQ;
    logic              storeQ;
    logic              flushQ;
    commitRec          recQ;
    logic [`XLEN-1:0]  redirectQ;

    // nicks run 1..ROB_DEPTH and skip 0
    function automatic robNick nextNick(robNick n);
        return (n == robNick'(`ROB_DEPTH)) ? robNick'(1) : n + 1'b1;
    endfunction

    // same-cycle writebacks bypass the entry state
    function automatic logic [`XLEN:0] probe(robNick n);
        if (n == '0) begin
            return '0;
        end
        if (exWb.en && exWb.nick == n) begin
            return {1'b1, exWb.data};
        end
        if (slbWb.en && slbWb.nick == n) begin
            return {1'b1, slbWb.data};
        end
        return {done[n], data[n]};
    endfunction

    assign {lookupDone1, lookupData1} = probe(lookupNick1);
    assign {lookupDone2, lookupData2} = probe(lookupNick2);

    assign allocNick = tail;
    assign full      = (count == `NICK_W'(`ROB_DEPTH));
    assign allocGo   = instEn && !full && !flushQ;
    assign headGo    = busy[head] && done[head] && !flushQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= `ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
                done[i] <= 1'b0;
            end
            head    <= robNick'(1);
            tail    <= robNick'(1);
            count   <= '0;
            commitQ <= 1'b0;
            storeQ  <= 1'b0;
            flushQ  <= 1'b0;
        end else if (rdy) begin
            commitQ <= 1'b0;
            storeQ  <= 1'b0;
            flushQ  <= 1'b0;
            if (flushQ) begin
                // whole queue goes, numbering restarts at 1
                for (int i = 1; i <= `ROB_DEPTH; i++) begin
                    busy[i] <= 1'b0;
                    done[i] <= 1'b0;
                end
                head  <= robNick'(1);
                tail  <= robNick'(1);
                count <= '0;
            end else begin
                if (allocGo) begin
                    busy[tail]     <= 1'b1;
                    done[tail]     <= 1'b0;
                    taken[tail]    <= 1'b0;
                    isStoreE[tail] <= isStore(instOp);
                    isBranch[tail] <= instOp inside {OpBranch, OpJal, OpJalr};
                    // decode hands rd 0 to ops without a destination
                    regName[tail]  <= instRd;
                    target[tail]   <= instPc + `XLEN'(4);
                    tail           <= nextNick(tail);
                end
                if (exWb.en) begin
                    done[exWb.nick] <= 1'b1;
                    data[exWb.nick] <= exWb.data;
                    if (exWb.isBranch) begin
                        taken[exWb.nick]  <= 1'b1;
                        target[exWb.nick] <= exWb.target;
                    end
                end
                if (slbWb.en) begin
                    done[slbWb.nick] <= 1'b1;
                    data[slbWb.nick] <= slbWb.data;
                end
                if (headGo) begin
                    busy[head]   <= 1'b0;
                    head         <= nextNick(head);
                    // jal/jalr link still written alongside a flush
                    commitQ      <= !isStoreE[head] && regName[head] != '0;
                    storeQ       <= isStoreE[head];
                    flushQ       <= isBranch[head] && taken[head];
                    recQ.regName <= regName[head];
                    recQ.data    <= data[head];
                    recQ.nick    <= head;
                    redirectQ    <= target[head];
                end
                count <= count + `NICK_W'(allocGo) - `NICK_W'(headGo);
            end
        end
    end

    assign commitEn        = commitQ && rdy;
    assign commit          = recQ;
    assign storeCommitEn   = storeQ && rdy;
    assign storeCommitNick = recQ.nick;
    assign flush           = flushQ && rdy;
    assign redirectPc      = redirectQ;

    exWbLive: assert property (@(posedge clk) disable iff (rst)
        rdy && exWb.en |-> exWb.nick != '0 && busy[exWb.nick]);

    slbWbLive: assert property (@(posedge clk) disable iff (rst)
        rdy && slbWb.en |-> slbWb.nick != '0 && busy[slbWb.nick]);

    noIssueWhenFull: assert property (@(posedge clk) disable iff (rst)
        rdy && instEn |-> !full);

endmodule

// ==== verilog/robBackend.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module robBackend (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              instEn,
    input  logic [`OP_W-1:0]  instOp,
    input  logic [`XLEN-1:0]  instPc,
    input  logic [`XLEN-1:0]  instImm,
    input  logic [`REG_W-1:0] instRd,
    input  logic [`REG_W-1:0] instRs1,
    input  logic [`REG_W-1:0] instRs2,
    output logic              rsEn,
    output logic [`OP_W-1:0]  rsOp,
    output logic [`XLEN-1:0]  rsPc,
    output logic [`XLEN-1:0]  rsImm,
    output robPkg::robNick    rsRdNick,
    output robPkg::robNick    rsRs1Nick,
    output logic [`XLEN-1:0]  rsRs1Data,
    output robPkg::robNick    rsRs2Nick,
    output logic [`XLEN-1:0]  rsRs2Data,
    output logic              slbEn,
    output logic [`OP_W-1:0]  slbOp,
    output logic [`XLEN-1:0]  slbPc,
    output logic [`XLEN-1:0]  slbImm,
    output robPkg::robNick    slbRdNick,
    output robPkg::robNick    slbRs1Nick,
    output logic [`XLEN-1:0]  slbRs1Data,
    output robPkg::robNick    slbRs2Nick,
    output logic [`XLEN-1:0]  slbRs2Data,
    input  logic              exEn,
    input  robPkg::robNick    exNick,
    input  logic [`XLEN-1:0]  exData,
    input  logic              exIsBranch,
    input  logic [`XLEN-1:0]  exTarget,
    input  logic              slbWbEn,
    input  robPkg::robNick    slbWbNick,
    input  logic [`XLEN-1:0]  slbWbData,
    output logic              rfEn,
    output logic [`REG_W-1:0] rfRegName,
    output logic [`XLEN-1:0]  rfData,
    output robPkg::robNick    rfNick,
    output logic              storeCommitEn,
    output robPkg::robNick    storeCommitNick,
    output logic              flush,
    output logic [`XLEN-1:0]  redirectPc,
    output logic              full
);
    import robPkg::*;

    issueIf rsIssue ();
    issueIf slbIssue ();
    wbIf    exWb ();
    wbIf    slbWb ();

    robNick           allocNick;
    robNick           rs1Nick;
    robNick           rs2Nick;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    robNick           lookupNick1;
    robNick           lookupNick2;
    logic             lookupDone1;
    logic             lookupDone2;
    logic [`XLEN-1:0] lookupData1;
    logic [`XLEN-1:0] lookupData2;
    commitRec         commit;

    assign exWb.en        = exEn;
    assign exWb.nick      = exNick;
    assign exWb.data      = exData;
    assign exWb.isBranch  = exIsBranch;
    assign exWb.target    = exTarget;

    // memory results never redirect
    assign slbWb.en       = slbWbEn;
    assign slbWb.nick     = slbWbNick;
    assign slbWb.data     = slbWbData;
    assign slbWb.isBranch = 1'b0;
    assign slbWb.target   = '0;

    renameTable uRename (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .instEn(instEn && !full),
        .instRd(instRd),
        .instRs1(instRs1),
        .instRs2(instRs2),
        .allocNick(allocNick),
        .commitEn(rfEn),
        .commit(commit),
        .flush(flush),
        .lookupNick1(lookupNick1),
        .lookupNick2(lookupNick2),
        .lookupDone1(lookupDone1),
        .lookupDone2(lookupDone2),
        .lookupData1(lookupData1),
        .lookupData2(lookupData2),
        .rs1Nick(rs1Nick),
        .rs1Data(rs1Data),
        .rs2Nick(rs2Nick),
        .rs2Data(rs2Data)
    );

    dispatchRouter uRouter (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .instEn(instEn && !full),
        .instOp(instOp),
        .instPc(instPc),
        .instImm(instImm),
        .allocNick(allocNick),
        .rs1Nick(rs1Nick),
        .rs1Data(rs1Data),
        .rs2Nick(rs2Nick),
        .rs2Data(rs2Data),
        .rsIssue(rsIssue),
        .slbIssue(slbIssue),
        .flush(flush)
    );

    reorderBuffer uRob (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .instEn(instEn),
        .instOp(instOp),
        .instRd(instRd),
        .instPc(instPc),
        .allocNick(allocNick),
        .full(full),
        .exWb(exWb),
        .slbWb(slbWb),
        .lookupNick1(lookupNick1),
        .lookupNick2(lookupNick2),
        .lookupDone1(lookupDone1),
        .lookupDone2(lookupDone2),
        .lookupData1(lookupData1),
        .lookupData2(lookupData2),
        .commitEn(rfEn),
        .commit(commit),
        .storeCommitEn(storeCommitEn),
        .storeCommitNick(storeCommitNick),
        .flush(flush),
        .redirectPc(redirectPc)
    );

    assign rsEn       = rsIssue.en;
    assign rsOp       = rsIssue.pkt.op;
    assign rsPc       = rsIssue.pkt.pc;
    assign rsImm      = rsIssue.pkt.imm;
    assign rsRdNick   = rsIssue.pkt.rdNick;
    assign rsRs1Nick  = rsIssue.pkt.rs1Nick;
    assign rsRs1Data  = rsIssue.pkt.rs1Data;
    assign rsRs2Nick  = rsIssue.pkt.rs2Nick;
    assign rsRs2Data  = rsIssue.pkt.rs2Data;

    assign slbEn      = slbIssue.en;
    assign slbOp      = slbIssue.pkt.op;
    assign slbPc      = slbIssue.pkt.pc;
    assign slbImm     = slbIssue.pkt.imm;
    assign slbRdNick  = slbIssue.pkt.rdNick;
    assign slbRs1Nick = slbIssue.pkt.rs1Nick;
    assign slbRs1Data = slbIssue.pkt.rs1Data;
    assign slbRs2Nick = slbIssue.pkt.rs2Nick;
    assign slbRs2Data = slbIssue.pkt.rs2Data;

    assign rfRegName  = commit.regName;
    assign rfData     = commit.data;
    assign rfNick     = commit.nick;

endmodule

// ==== sim/tb_robBackend.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module tb_robBackend;
    import robPkg::*;

    localparam int waitLimit = 60;
    localparam int kindIssue = 0;
    localparam int kindRf = 1;
    localparam int kindStore = 2;
    localparam int kindFlush = 3;

    logic clk, rst, rdy, instEn;
    logic [`OP_W-1:0] instOp;
    logic [`XLEN-1:0] instPc, instImm;
    logic [`REG_W-1:0] instRd, instRs1, instRs2;
    logic rsEn, slbEn;
    logic [`OP_W-1:0] rsOp, slbOp;
    logic [`XLEN-1:0] rsPc, rsImm, rsRs1Data, rsRs2Data;
    logic [`XLEN-1:0] slbPc, slbImm, slbRs1Data, slbRs2Data;
    robNick rsRdNick, rsRs1Nick, rsRs2Nick, slbRdNick, slbRs1Nick, slbRs2Nick;
    logic exEn, exIsBranch, slbWbEn;
    robNick exNick, slbWbNick;
    logic [`XLEN-1:0] exData, exTarget, slbWbData;
    logic rfEn, storeCommitEn, flush, full;
    logic [`REG_W-1:0] rfRegName;
    logic [`XLEN-1:0] rfData, redirectPc;
    robNick rfNick, storeCommitNick;

    // reference model: architectural registers and per-nick expectations
    logic [`XLEN-1:0] modelRegs [32];
    logic [`REG_W-1:0] expRd [16];
    logic expStore [16];
    logic [`XLEN-1:0] wbVal [16];
    robNick modelTail;

    logic pathQ [$];
    issuePkt pktQ [$];
    commitRec rfQ [$];
    robNick storeQ [$];
    logic [`XLEN-1:0] flushQ [$];

    int errors;
    int checks;
    integer seed;

    robBackend UUT (.*);

    always #4 clk = ~clk;

    // outputs are sampled mid-cycle and queued for the tests
    always @(negedge clk) begin
        if (!rst) begin
            if (rsEn && slbEn) begin
                errors++;
                $display("rsEn and slbEn were both high at %0t", $time);
            end
            if (rsEn) begin
                pathQ.push_back(1'b0);
                pktQ.push_back({rsOp, rsPc, rsImm, rsRdNick, rsRs1Nick, rsRs1Data,
                                rsRs2Nick, rsRs2Data});
            end
            if (slbEn) begin
                pathQ.push_back(1'b1);
                pktQ.push_back({slbOp, slbPc, slbImm, slbRdNick, slbRs1Nick, slbRs1Data,
                                slbRs2Nick, slbRs2Data});
            end
            if (rfEn && rfRegName == '0) begin
                errors++;
                $display("rfEn reported a write to x0 at %0t", $time);
            end
            if (rfEn) begin
                rfQ.push_back({rfRegName, rfData, rfNick});
            end
            if (storeCommitEn) begin
                storeQ.push_back(storeCommitNick);
            end
            if (flush) begin
                flushQ.push_back(redirectPc);
            end
        end
    end

    task automatic checkValue(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic int pending(input int kind);
        case (kind)
            kindIssue: return pathQ.size();
            kindRf:    return rfQ.size();
            kindStore: return storeQ.size();
            default:   return flushQ.size();
        endcase
    endfunction

    task automatic awaitEvent(input int kind, input string what, output bit ok);
        int t;
        t = 0;
        while (pending(kind) == 0 && t < waitLimit) begin
            @(posedge clk);
            t++;
        end
        ok = pending(kind) != 0;
        if (!ok) begin
            errors++;
            $display("timed out waiting for %s at %0t", what, $time);
        end
    endtask

    task automatic issue(input logic [`OP_W-1:0] op, input logic [`XLEN-1:0] pc,
                         input logic [`XLEN-1:0] imm, input logic [`REG_W-1:0] rd,
                         input logic [`REG_W-1:0] rs1, input logic [`REG_W-1:0] rs2,
                         output robNick nick);
        @(posedge clk);
        instEn <= 1'b1;
        instOp <= op;
        instPc <= pc;
        instImm <= imm;
        instRd <= rd;
        instRs1 <= rs1;
        instRs2 <= rs2;
        @(posedge clk);
        instEn <= 1'b0;
        nick = modelTail;
        expRd[nick] = rd;
        expStore[nick] = op inside {OpStoreB, OpStoreH, OpStoreW};
        modelTail = (modelTail == robNick'(`ROB_DEPTH)) ? robNick'(1) : modelTail + 1'b1;
    endtask

    task automatic checkIssue(input logic toSlb, input logic [`OP_W-1:0] op,
                              input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] imm,
                              input robNick nick, input robNick n1,
                              input logic [`XLEN-1:0] d1, input robNick n2,
                              input logic [`XLEN-1:0] d2);
        bit ok;
        logic path;
        issuePkt pkt;
        awaitEvent(kindIssue, "an issue strobe", ok);
        if (ok) begin
            path = pathQ.pop_front();
            pkt = pktQ.pop_front();
            checkValue("slbEn", path, toSlb);
            checkValue("op", pkt.op, op);
            checkValue("pc", pkt.pc, pc);
            checkValue("imm", pkt.imm, imm);
            checkValue("rdNick", pkt.rdNick, nick);
            checkValue("rs1Nick", pkt.rs1Nick, n1);
            checkValue("rs2Nick", pkt.rs2Nick, n2);
            // data only matters once the operand is resolved
            if (n1 == '0) begin
                checkValue("rs1Data", pkt.rs1Data, d1);
            end
            if (n2 == '0) begin
                checkValue("rs2Data", pkt.rs2Data, d2);
            end
        end
    endtask

    task automatic writeback(input logic viaSlb, input robNick nick,
                             input logic [`XLEN-1:0] data, input logic br,
                             input logic [`XLEN-1:0] tgt);
        @(posedge clk);
        if (viaSlb) begin
            slbWbEn <= 1'b1;
            slbWbNick <= nick;
            slbWbData <= data;
        end else begin
            exEn <= 1'b1;
            exNick <= nick;
            exData <= data;
            exIsBranch <= br;
            exTarget <= tgt;
        end
        @(posedge clk);
        exEn <= 1'b0;
        exIsBranch <= 1'b0;
        slbWbEn <= 1'b0;
        wbVal[nick] = data;
    endtask

    task automatic expectCommit(input robNick nick);
        bit ok;
        commitRec rec;
        robNick sn;
        if (expStore[nick]) begin
            awaitEvent(kindStore, "storeCommitEn", ok);
            if (ok) begin
                sn = storeQ.pop_front();
                checkValue("storeCommitNick", sn, nick);
            end
        end else if (expRd[nick] != '0) begin
            awaitEvent(kindRf, "rfEn", ok);
            if (ok) begin
                rec = rfQ.pop_front();
                checkValue("rfRegName", rec.regName, expRd[nick]);
                checkValue("rfData", rec.data, wbVal[nick]);
                checkValue("rfNick", rec.nick, nick);
                modelRegs[expRd[nick]] = wbVal[nick];
            end
        end
    endtask

    task automatic expectQuiet(input string testName);
        repeat (4) @(posedge clk);
        if (pathQ.size() + rfQ.size() + storeQ.size() + flushQ.size() != 0) begin
            errors++;
            $display("%s left unexpected output events", testName);
            pathQ.delete();
            pktQ.delete();
            rfQ.delete();
            storeQ.delete();
            flushQ.delete();
        end
    endtask

    task automatic testRouting();
        logic [`OP_W-1:0] ops [12] = '{OpLoadB, OpLoadH, OpLoadW, OpLoadBU, OpLoadHU,
            OpStoreB, OpStoreH, OpStoreW, OpBranch, OpJal, OpJalr, OpAlu};
        logic [`OP_W-1:0] op;
        logic isSt;
        logic isMem;
        logic [`REG_W-1:0] rd;
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        robNick expNick;
        robNick nick;
        for (int i = 0; i < 20; i++) begin
            op = ops[i % 12];
            isSt = op inside {OpStoreB, OpStoreH, OpStoreW};
            isMem = isSt || op inside {OpLoadB, OpLoadH, OpLoadW, OpLoadBU, OpLoadHU};
            rd = isSt ? 5'd0 : 5'((i % 31) + 1);
            rs1 = 5'(i % 8);
            rs2 = 5'((i + 3) % 8);
            expNick = robNick'((i % 15) + 1);
            issue(op, 32'h1000 + 4 * i, 32'h55 ^ (3 * i), rd, rs1, rs2, nick);
            checkIssue(isMem, op, 32'h1000 + 4 * i, 32'h55 ^ (3 * i), expNick,
                       '0, modelRegs[rs1], '0, modelRegs[rs2]);
            writeback(isMem, nick, 32'hC0DE0000 + i, 1'b0, '0);
            expectCommit(nick);
        end
        expectQuiet("routing test");
    endtask

    task automatic testInOrderCommit();
        logic [`REG_W-1:0] rds [6] = '{5'd11, 5'd12, 5'd0, 5'd13, 5'd14, 5'd15};
        robNick nicks [6];
        int order [6];
        int j;
        int tmp;
        for (int k = 0; k < 6; k++) begin
            issue(OpAlu, 32'h2000 + 4 * k, k, rds[k], 5'd0, 5'd0, nicks[k]);
            checkIssue(1'b0, OpAlu, 32'h2000 + 4 * k, k, nicks[k], '0, '0, '0, '0);
            order[k] = k;
        end
        // shuffle the writeback order
        for (int k = 5; k > 0; k--) begin
            j = $unsigned($random(seed)) % (k + 1);
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < 6; k++) begin
            writeback(1'b0, nicks[order[k]], $random(seed), 1'b0, '0);
        end
        for (int k = 0; k < 6; k++) begin
            expectCommit(nicks[k]);
        end
        expectQuiet("in-order commit test");
    endtask

    task automatic testOperands();
        robNick p;
        robNick c1;
        robNick c2;
        robNick c3;
        issue(OpAlu, 32'h3000, 0, 5'd6, 5'd0, 5'd0, p);
        checkIssue(1'b0, OpAlu, 32'h3000, 0, p, '0, '0, '0, '0);
        issue(OpAlu, 32'h3004, 1, 5'd7, 5'd6, 5'd3, c1);
        checkIssue(1'b0, OpAlu, 32'h3004, 1, c1, p, '0, '0, modelRegs[3]);
        writeback(1'b0, p, 32'h600D0006, 1'b0, '0);
        // producer done but maybe not yet committed
        issue(OpAlu, 32'h3008, 2, 5'd8, 5'd6, 5'd0, c2);
        checkIssue(1'b0, OpAlu, 32'h3008, 2, c2, '0, 32'h600D0006, '0, '0);
        expectCommit(p);
        issue(OpAlu, 32'h300C, 3, 5'd9, 5'd6, 5'd7, c3);
        checkIssue(1'b0, OpAlu, 32'h300C, 3, c3, '0, modelRegs[6], c1, '0);
        writeback(1'b0, c1, 32'h71, 1'b0, '0);
        writeback(1'b0, c3, 32'h93, 1'b0, '0);
        writeback(1'b0, c2, 32'h82, 1'b0, '0);
        expectCommit(c1);
        expectCommit(c2);
        expectCommit(c3);
        expectQuiet("operand test");
    endtask

    task automatic testFull();
        robNick nicks [15];
        for (int k = 0; k < 15; k++) begin
            issue(OpAlu, 32'h4000 + 4 * k, k, 5'(k + 1), 5'd0, 5'd0, nicks[k]);
            checkIssue(1'b0, OpAlu, 32'h4000 + 4 * k, k, nicks[k], '0, '0, '0, '0);
            @(negedge clk);
            checkValue("full", full, k == 14);
        end
        writeback(1'b0, nicks[0], 32'hF000, 1'b0, '0);
        expectCommit(nicks[0]);
        @(negedge clk);
        checkValue("full", full, 1'b0);
        for (int k = 1; k < 15; k++) begin
            writeback(1'b0, nicks[k], 32'hF000 + k, 1'b0, '0);
            expectCommit(nicks[k]);
        end
        expectQuiet("full test");
    endtask

    task automatic testStoreCommit();
        robNick s;
        issue(OpStoreW, 32'h5000, 32'h10, 5'd0, 5'd1, 5'd2, s);
        checkIssue(1'b1, OpStoreW, 32'h5000, 32'h10, s, '0, modelRegs[1], '0, modelRegs[2]);
        writeback(1'b1, s, 32'h0, 1'b0, '0);
        expectCommit(s);
        expectQuiet("store commit test");
    endtask

    task automatic testBranchFlush();
        robNick a;
        robNick b;
        robNick c;
        robNick d;
        robNick e;
        bit ok;
        logic [`XLEN-1:0] pc;
        issue(OpAlu, 32'h6000, 0, 5'd2, 5'd0, 5'd0, a);
        checkIssue(1'b0, OpAlu, 32'h6000, 0, a, '0, '0, '0, '0);
        issue(OpBranch, 32'h6004, 32'h40, 5'd0, 5'd1, 5'd2, b);
        checkIssue(1'b0, OpBranch, 32'h6004, 32'h40, b, '0, modelRegs[1], a, '0);
        issue(OpAlu, 32'h6008, 1, 5'd3, 5'd0, 5'd0, c);
        checkIssue(1'b0, OpAlu, 32'h6008, 1, c, '0, '0, '0, '0);
        issue(OpAlu, 32'h600C, 2, 5'd4, 5'd0, 5'd0, d);
        checkIssue(1'b0, OpAlu, 32'h600C, 2, d, '0, '0, '0, '0);
        writeback(1'b0, c, 32'hBAD00003, 1'b0, '0);
        writeback(1'b0, d, 32'hBAD00004, 1'b0, '0);
        writeback(1'b0, a, 32'hAAAA0002, 1'b0, '0);
        expectCommit(a);
        writeback(1'b0, b, 32'h0, 1'b1, 32'h8000);
        awaitEvent(kindFlush, "flush", ok);
        if (ok) begin
            pc = flushQ.pop_front();
            checkValue("redirectPc", pc, 32'h8000);
        end
        // numbering restarts after a flush
        modelTail = robNick'(1);
        issue(OpAlu, 32'h8000, 5, 5'd5, 5'd3, 5'd2, e);
        checkIssue(1'b0, OpAlu, 32'h8000, 5, robNick'(1), '0, modelRegs[3], '0, modelRegs[2]);
        writeback(1'b0, e, 32'h5555, 1'b0, '0);
        expectCommit(e);
        expectQuiet("branch flush test");
    endtask

    initial begin
        #100000;
        $display("simulation watchdog expired at %0t", $time);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        instEn = 1'b0;
        instOp = '0;
        instPc = '0;
        instImm = '0;
        instRd = '0;
        instRs1 = '0;
        instRs2 = '0;
        exEn = 1'b0;
        exNick = '0;
        exData = '0;
        exIsBranch = 1'b0;
        exTarget = '0;
        slbWbEn = 1'b0;
        slbWbNick = '0;
        slbWbData = '0;
        errors = 0;
        checks = 0;
        seed = 29065;
        modelTail = robNick'(1);
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("rsEn", rsEn, 1'b0);
        checkValue("slbEn", slbEn, 1'b0);
        checkValue("rfEn", rfEn, 1'b0);
        checkValue("storeCommitEn", storeCommitEn, 1'b0);
        checkValue("flush", flush, 1'b0);
        checkValue("full", full, 1'b0);
        testRouting();
        testInOrderCommit();
        testOperands();
        testFull();
        testStoreCommit();
        testBranchFlush();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/robPkg.sv
verilog/robIf.sv
verilog/renameTable.sv
verilog/dispatchRouter.sv
verilog/reorderBuffer.sv
verilog/robBackend.sv
sim/tb_robBackend.sv

// ==== Bender.yml ====
package:
  name: rob_backend

export_include_dirs:
  - verilog

sources:
  - verilog/robPkg.sv
  - verilog/robIf.sv
  - verilog/renameTable.sv
  - verilog/dispatchRouter.sv
  - verilog/reorderBuffer.sv
  - verilog/robBackend.sv
  - target: simulation
    files:
      - sim/tb_robBackend.sv
